// ==== logic/rename_pkg.sv ====
// ============================================================
// register counts and index types for the rename stage
// rename request / response and commit record structs
// ============================================================

package rename_pkg;

    // ========================================================
    // register file sizes
    // ========================================================
    // arch reg 0 is hardwired, always maps to phys reg 0
    localparam int unsigned ARCH_REGS = 32;
    localparam int unsigned PHYS_REGS = 64;
    // registers not holding committed state
    localparam int unsigned FREE_REGS = PHYS_REGS - ARCH_REGS;

    typedef logic [$clog2(ARCH_REGS)-1:0]   arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0]   phys_reg_t;
    // 0 .. FREE_REGS inclusive
    typedef logic [$clog2(FREE_REGS+1)-1:0] free_cnt_t;

    // ========================================================
    // per-lane records
    // ========================================================
    // one decoded instruction entering rename
    typedef struct packed {
        logic      valid;
        logic      dest_valid;
        arch_reg_t arch_rd;
        arch_reg_t arch_rs1;
        arch_reg_t arch_rs2;
    } rename_req_t;

    // renamed operands, old_phys_rd goes to the ROB
    typedef struct packed {
        logic      valid;
        phys_reg_t phys_rd;
        phys_reg_t old_phys_rd;
        phys_reg_t phys_rs1;
        phys_reg_t phys_rs2;
    } rename_rsp_t;

    // in-order retirement from the ROB
    typedef struct packed {
        logic      valid;
        logic      dest_valid;
        arch_reg_t arch_rd;
        phys_reg_t phys_rd;
        phys_reg_t old_phys_rd;
    } commit_t;

endpackage

// ==== logic/free_list.sv ====
// ============================================================
// circular FIFO of free physical registers
// release-first allocation, retire pointer, flush rewind
// ============================================================
`timescale 1ns/10ps

module free_list import rename_pkg::*; #(
    parameter int unsigned DISPATCH_WIDTH = 2,
    parameter int unsigned COMMIT_WIDTH   = 2
) (
    input  logic                           clock,
    input  logic                           reset,
    // dispatch side
    input  logic [DISPATCH_WIDTH-1:0]      alloc_req_i,
    output logic                           alloc_ok_o,
    output phys_reg_t [DISPATCH_WIDTH-1:0] alloc_phys_o,
    // commit side
    input  commit_t [COMMIT_WIDTH-1:0]     commit_i,
    input  logic                           flush_i,
    output free_cnt_t                      free_count_o
);

    localparam int unsigned PTR_W = $clog2(FREE_REGS);

    typedef logic [PTR_W-1:0] ptr_t;

    // ring of FREE_REGS slots
    // retire..head  taken by in-flight renames
    // head..tail    free
    phys_reg_t fifo_q [FREE_REGS];
    ptr_t      head_q;
    ptr_t      tail_q;
    ptr_t      retire_q;
    free_cnt_t count_q;

    // releases this cycle, compacted in commit order
    logic      [COMMIT_WIDTH-1:0] rel_valid;
    ptr_t      [COMMIT_WIDTH-1:0] rel_slot;
    phys_reg_t [COMMIT_WIDTH-1:0] rel_list;
    int unsigned                  n_rel;
    int unsigned                  n_req;

    assign free_count_o = count_q;

    // ========================================================
    // release: old mappings pushed at the tail
    // ========================================================
    always_comb begin
        n_rel     = 0;
        rel_valid = '0;
        rel_slot  = '0;
        rel_list  = '0;
        for (int j = 0; j < COMMIT_WIDTH; j++) begin
            // phys reg 0 belongs to arch reg 0, never freed
            if (commit_i[j].valid && commit_i[j].dest_valid &&
                commit_i[j].old_phys_rd != '0) begin
                rel_valid[j]    = 1'b1;
                rel_slot[j]     = tail_q + ptr_t'(n_rel);
                rel_list[n_rel] = commit_i[j].old_phys_rd;
                n_rel           = n_rel + 1;
            end
        end
    end

    // ========================================================
    // allocation: k-th requester gets k-th entry from head
    // ========================================================
    always_comb begin
        n_req        = 0;
        alloc_phys_o = '0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (alloc_req_i[i]) begin
                if (n_req < count_q) begin
                    // already sitting in the ring
                    alloc_phys_o[i] = fifo_q[head_q + ptr_t'(n_req)];
                end else if (n_req - count_q < n_rel) begin
                    // bypass from this cycle's releases
                    alloc_phys_o[i] = rel_list[n_req - count_q];
                end
                n_req = n_req + 1;
            end
        end
        // all-or-nothing for the whole group
        alloc_ok_o = (n_req <= count_q + n_rel) && !flush_i;
    end

    // ========================================================
    // pointers and count
    // ========================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q   <= '0;
            tail_q   <= '0;
            retire_q <= '0;
            count_q  <= free_cnt_t'(FREE_REGS);
        end else begin
            // commits retire in order, pointers move together
            tail_q   <= tail_q + ptr_t'(n_rel);
            retire_q <= retire_q + ptr_t'(n_rel);
            if (flush_i) begin
                // squashed renames give their regs back
                head_q  <= retire_q + ptr_t'(n_rel);
                count_q <= free_cnt_t'(FREE_REGS);
            end else if (alloc_ok_o) begin
                head_q  <= head_q + ptr_t'(n_req);
                count_q <= count_q + free_cnt_t'(n_rel) - free_cnt_t'(n_req);
            end else begin
                // stalled, only releases land
                count_q <= count_q + free_cnt_t'(n_rel);
            end
        end
    end

    // ========================================================
    // ring storage
    // ========================================================
    // starts full with the regs above the arch range
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < FREE_REGS; k++) begin
                fifo_q[k] <= phys_reg_t'(k + ARCH_REGS);
            end
        end else begin
            // slot at tail held the reg now committed
            for (int j = 0; j < COMMIT_WIDTH; j++) begin
                if (rel_valid[j]) begin
                    fifo_q[rel_slot[j]] <= commit_i[j].old_phys_rd;
                end
            end
        end
    end

endmodule

// ==== logic/map_table.sv ====
// ============================================================
// speculative arch-to-phys map table
// source lookup with in-group forwarding, flush restore
// ============================================================
`timescale 1ns/10ps

module map_table import rename_pkg::*; #(
    parameter int unsigned DISPATCH_WIDTH = 2,
    parameter int unsigned COMMIT_WIDTH   = 2
) (
    input  logic                             clock,
    input  logic                             reset,
    // rename group from decode
    input  rename_req_t [DISPATCH_WIDTH-1:0] rename_req_i,
    output rename_rsp_t [DISPATCH_WIDTH-1:0] rename_rsp_o,
    // free list handshake
    output logic        [DISPATCH_WIDTH-1:0] alloc_req_o,
    input  logic                             alloc_ok_i,
    input  phys_reg_t   [DISPATCH_WIDTH-1:0] alloc_phys_i,
    // recovery
    input  logic                             flush_i,
    input  phys_reg_t   [ARCH_REGS-1:0]      arch_next_map_i
);

    phys_reg_t [ARCH_REGS-1:0] map_q;

    // ========================================================
    // lane requests
    // ========================================================
    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            // writes to arch reg 0 are dropped
            alloc_req_o[i] = rename_req_i[i].valid && rename_req_i[i].dest_valid &&
                             rename_req_i[i].arch_rd != '0;
        end
    end

    // ========================================================
    // lookup and forwarding
    // ========================================================
    always_comb begin
        rename_rsp_t rsp;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            // alloc_ok is low on stall and flush
            rsp.valid       = rename_req_i[i].valid && alloc_ok_i;
            rsp.phys_rd     = alloc_req_o[i] ? alloc_phys_i[i] : '0;
            rsp.old_phys_rd = alloc_req_o[i] ? map_q[rename_req_i[i].arch_rd] : '0;
            rsp.phys_rs1    = map_q[rename_req_i[i].arch_rs1];
            rsp.phys_rs2    = map_q[rename_req_i[i].arch_rs2];
            // earlier lanes override the table, nearest lane last
            for (int p = 0; p < i; p++) begin
                if (alloc_req_o[p]) begin
                    if (rename_req_i[p].arch_rd == rename_req_i[i].arch_rs1) begin
                        rsp.phys_rs1 = alloc_phys_i[p];
                    end
                    if (rename_req_i[p].arch_rd == rename_req_i[i].arch_rs2) begin
                        rsp.phys_rs2 = alloc_phys_i[p];
                    end
                    if (alloc_req_o[i] &&
                        rename_req_i[p].arch_rd == rename_req_i[i].arch_rd) begin
                        rsp.old_phys_rd = alloc_phys_i[p];
                    end
                end
            end
            rename_rsp_o[i] = rsp;
        end
    end

    // ========================================================
    // table update
    // ========================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // identity map
            for (int a = 0; a < ARCH_REGS; a++) begin
                map_q[a] <= phys_reg_t'(a);
            end
        end else if (flush_i) begin
            // back to committed state incl. this cycle's commits
            map_q <= arch_next_map_i;
        end else if (alloc_ok_i) begin
            // later lanes win on same arch_rd
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                if (alloc_req_o[i]) begin
                    map_q[rename_req_i[i].arch_rd] <= alloc_phys_i[i];
                end
            end
        end
    end

endmodule

// ==== logic/arch_map.sv ====
// ============================================================
// committed arch-to-phys map, written by commit records
// ============================================================
`timescale 1ns/10ps

module arch_map import rename_pkg::*; #(
    parameter int unsigned DISPATCH_WIDTH = 2,
    parameter int unsigned COMMIT_WIDTH   = 2
) (
    input  logic                          clock,
    input  logic                          reset,
    input  commit_t   [COMMIT_WIDTH-1:0]  commit_i,
    // next-state map, used for flush restore
    output phys_reg_t [ARCH_REGS-1:0]     arch_next_map_o
);

    phys_reg_t [ARCH_REGS-1:0] map_q;

    // ========================================================
    // commit writes
    // ========================================================
    always_comb begin
        arch_next_map_o = map_q;
        // in-order lanes, youngest commit applied last
        for (int j = 0; j < COMMIT_WIDTH; j++) begin
            if (commit_i[j].valid && commit_i[j].dest_valid &&
                commit_i[j].arch_rd != '0) begin
                arch_next_map_o[commit_i[j].arch_rd] = commit_i[j].phys_rd;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // identity, same as the speculative map
            for (int a = 0; a < ARCH_REGS; a++) begin
                map_q[a] <= phys_reg_t'(a);
            end
        end else begin
            map_q <= arch_next_map_o;
        end
    end

endmodule

// ==== logic/rename_stage.sv ====
// ============================================================
// register rename stage top level
// map table, free list and committed map
// ============================================================
`timescale 1ns/10ps

module rename_stage import rename_pkg::*; #(
    parameter int unsigned DISPATCH_WIDTH = 2,
    parameter int unsigned COMMIT_WIDTH   = 2
) (
    input  logic                             clock,
    input  logic                             reset,
    // dispatch group
    input  rename_req_t [DISPATCH_WIDTH-1:0] rename_req_i,
    output rename_rsp_t [DISPATCH_WIDTH-1:0] rename_rsp_o,
    output logic                             stall_o,
    // retirement and recovery
    input  commit_t     [COMMIT_WIDTH-1:0]   commit_i,
    input  logic                             flush_i,
    output free_cnt_t                        free_count_o
);

    logic      [DISPATCH_WIDTH-1:0] alloc_req;
    logic                           alloc_ok;
    phys_reg_t [DISPATCH_WIDTH-1:0] alloc_phys;
    phys_reg_t [ARCH_REGS-1:0]      arch_next_map;

    // group holds while free list is short
    assign stall_o = ~alloc_ok;

    // ========================================================
    // blocks
    // ========================================================
    map_table #(
        .DISPATCH_WIDTH (DISPATCH_WIDTH),
        .COMMIT_WIDTH   (COMMIT_WIDTH)
    ) map_table_i (
        .clock           (clock),
        .reset           (reset),
        .rename_req_i    (rename_req_i),
        .rename_rsp_o    (rename_rsp_o),
        .alloc_req_o     (alloc_req),
        .alloc_ok_i      (alloc_ok),
        .alloc_phys_i    (alloc_phys),
        .flush_i         (flush_i),
        .arch_next_map_i (arch_next_map)
    );

    free_list #(
        .DISPATCH_WIDTH (DISPATCH_WIDTH),
        .COMMIT_WIDTH   (COMMIT_WIDTH)
    ) free_list_i (
        .clock        (clock),
        .reset        (reset),
        .alloc_req_i  (alloc_req),
        .alloc_ok_o   (alloc_ok),
        .alloc_phys_o (alloc_phys),
        .commit_i     (commit_i),
        .flush_i      (flush_i),
        .free_count_o (free_count_o)
    );

    arch_map #(
        .DISPATCH_WIDTH (DISPATCH_WIDTH),
        .COMMIT_WIDTH   (COMMIT_WIDTH)
    ) arch_map_i (
        .clock           (clock),
        .reset           (reset),
        .commit_i        (commit_i),
        .arch_next_map_o (arch_next_map)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
// ============================================================
// testbench clock and power-on reset
// ============================================================
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int unsigned HALF_PERIOD  = 5,
    parameter int unsigned RESET_CYCLES = 10
) (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clock_o = ~clock_o;
        end
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        // release away from the active edge
        @(negedge clock_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== sim/rename_tb.sv ====
// ============================================================
// rename stage testbench
// reference model of both maps, the free FIFO and in-flight renames
// concurrent checks on response, stall and free count
// ============================================================
`timescale 1ns/10ps

module rename_tb import rename_pkg::*; ();

    localparam int unsigned DISPATCH_WIDTH = 2;
    localparam int unsigned COMMIT_WIDTH   = 2;
    localparam int unsigned WAIT_LIMIT     = 64;

    typedef rename_req_t [DISPATCH_WIDTH-1:0] group_t;

    logic                             clock;
    logic                             reset;
    group_t                           req_d;
    commit_t     [COMMIT_WIDTH-1:0]   commit_d;
    logic                             flush_d;
    rename_rsp_t [DISPATCH_WIDTH-1:0] rename_rsp;
    logic                             stall;
    free_cnt_t                        free_count;

    // expected values, settled at the falling edge
    rename_rsp_t [DISPATCH_WIDTH-1:0] exp_rsp;
    logic                             exp_stall;
    free_cnt_t                        exp_count;

    // reference model state
    phys_reg_t spec_map [ARCH_REGS];
    phys_reg_t comm_map [ARCH_REGS];
    phys_reg_t free_q [$];
    commit_t   inflight_q [$];

    int     errors;
    int     timeouts;
    integer seed;

    tb_clock_gen #(.HALF_PERIOD(5), .RESET_CYCLES(10)) clock_gen_i (
        .clock_o (clock),
        .reset_o (reset)
    );

    rename_stage #(
        .DISPATCH_WIDTH (DISPATCH_WIDTH),
        .COMMIT_WIDTH   (COMMIT_WIDTH)
    ) dut_i (
        .clock        (clock),
        .reset        (reset),
        .rename_req_i (req_d),
        .rename_rsp_o (rename_rsp),
        .stall_o      (stall),
        .commit_i     (commit_d),
        .flush_i      (flush_d),
        .free_count_o (free_count)
    );

    // ========================================================
    // checks at the rising edge
    // ========================================================
    assert property (@(posedge clock) disable iff (reset) stall == exp_stall)
    else begin
        errors++;
        $display("[FAIL] stall_o: got %h expected %h", $sampled(stall), $sampled(exp_stall));
    end

    assert property (@(posedge clock) disable iff (reset) free_count == exp_count)
    else begin
        errors++;
        $display("[FAIL] free_count_o: got %h expected %h",
                 $sampled(free_count), $sampled(exp_count));
    end

    // fields are compared only where a lane is renamed
    for (genvar l = 0; l < DISPATCH_WIDTH; l++) begin : g_lane
        assert property (@(posedge clock) disable iff (reset)
            rename_rsp[l].valid == exp_rsp[l].valid &&
            (!exp_rsp[l].valid || rename_rsp[l] == exp_rsp[l]))
        else begin
            errors++;
            $display("[FAIL] rename_rsp_o[%0d]: got %h expected %h",
                     l, $sampled(rename_rsp[l]), $sampled(exp_rsp[l]));
        end
    end

    // ========================================================
    // model helpers
    // ========================================================
    function automatic logic allocates(input rename_req_t r);
        return r.valid && r.dest_valid && r.arch_rd != '0;
    endfunction

    function automatic rename_req_t make_req(input logic dest, input int rd,
                                             input int rs1, input int rs2);
        rename_req_t r;
        r.valid      = 1'b1;
        r.dest_valid = dest;
        r.arch_rd    = arch_reg_t'(rd);
        r.arch_rs1   = arch_reg_t'(rs1);
        r.arch_rs2   = arch_reg_t'(rs2);
        return r;
    endfunction

    // force_dest gives a valid lane that always needs a register
    function automatic rename_req_t random_req(input logic force_dest);
        rename_req_t r;
        r.valid      = force_dest || ($random(seed) % 8 != 0);
        r.dest_valid = force_dest || ($random(seed) % 4 != 0);
        r.arch_rd    = arch_reg_t'($random(seed));
        r.arch_rs1   = arch_reg_t'($random(seed));
        r.arch_rs2   = arch_reg_t'($random(seed));
        if (force_dest && r.arch_rd == '0) begin
            r.arch_rd = arch_reg_t'(1);
        end
        return r;
    endfunction

    task automatic reset_model();
        for (int a = 0; a < ARCH_REGS; a++) begin
            spec_map[a] = phys_reg_t'(a);
            comm_map[a] = phys_reg_t'(a);
        end
        free_q.delete();
        for (int k = 0; k < FREE_REGS; k++) begin
            free_q.push_back(phys_reg_t'(ARCH_REGS + k));
        end
        inflight_q.delete();
    endtask

    // one cycle: commits first, then the group in program order
    task automatic drive_cycle(input group_t group, input int n_commit, input logic do_flush);
        commit_t     [COMMIT_WIDTH-1:0]   cmt;
        rename_rsp_t [DISPATCH_WIDTH-1:0] rsp;
        phys_reg_t                        lane_map [ARCH_REGS];
        commit_t                          rec;
        int                               need;
        logic                             ok;
        @(negedge clock);
        exp_count = free_cnt_t'(free_q.size());
        cmt = '0;
        for (int j = 0; j < COMMIT_WIDTH; j++) begin
            if (j < n_commit && inflight_q.size() > 0) begin
                rec                   = inflight_q.pop_front();
                cmt[j]                = rec;
                comm_map[rec.arch_rd] = rec.phys_rd;
                if (rec.old_phys_rd != '0) begin
                    free_q.push_back(rec.old_phys_rd);
                end
            end
        end
        need = 0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            need += allocates(group[i]);
        end
        // released regs already sit at the back of the FIFO
        ok       = !do_flush && need <= free_q.size();
        rsp      = '0;
        lane_map = spec_map;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            rsp[i].phys_rs1 = lane_map[group[i].arch_rs1];
            rsp[i].phys_rs2 = lane_map[group[i].arch_rs2];
            if (ok && group[i].valid) begin
                rsp[i].valid = 1'b1;
                if (allocates(group[i])) begin
                    rsp[i].phys_rd             = free_q.pop_front();
                    rsp[i].old_phys_rd         = lane_map[group[i].arch_rd];
                    lane_map[group[i].arch_rd] = rsp[i].phys_rd;
                    rec = '{1'b1, 1'b1, group[i].arch_rd, rsp[i].phys_rd, rsp[i].old_phys_rd};
                    inflight_q.push_back(rec);
                end
            end
        end
        if (ok) begin
            spec_map = lane_map;
        end
        if (do_flush) begin
            // squashed regs go back ahead of the free ones
            for (int k = inflight_q.size() - 1; k >= 0; k--) begin
                free_q.push_front(inflight_q[k].phys_rd);
            end
            inflight_q.delete();
            spec_map = comm_map;
        end
        exp_rsp   = rsp;
        exp_stall = !ok;
        req_d     = group;
        commit_d  = cmt;
        flush_d   = do_flush;
    endtask

    // ========================================================
    // stimulus
    // ========================================================
    initial begin
        group_t group;
        int     n;
        seed      = 44;
        errors    = 0;
        timeouts  = 0;
        req_d     = '0;
        commit_d  = '0;
        flush_d   = 1'b0;
        exp_rsp   = '0;
        exp_stall = 1'b0;
        exp_count = free_cnt_t'(FREE_REGS);
        reset_model();

        // wait out the power-on reset
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (reset && n < WAIT_LIMIT);
        if (reset) begin
            timeouts++;
            $display("timeout: reset was never released");
        end

        // identity map, no destinations
        group[0] = make_req(1'b0, 0, 5, 9);
        group[1] = make_req(1'b0, 0, 31, 0);
        drive_cycle(group, 0, 1'b0);
        // first allocations, then a write to arch reg 0
        group[0] = make_req(1'b1, 3, 1, 2);
        group[1] = make_req(1'b1, 4, 3, 4);
        drive_cycle(group, 0, 1'b0);
        group[0] = make_req(1'b1, 0, 3, 4);
        group[1] = make_req(1'b1, 7, 0, 3);
        drive_cycle(group, 0, 1'b0);
        // lane 1 reads and rewrites lane 0's destination
        group[0] = make_req(1'b1, 10, 3, 4);
        group[1] = make_req(1'b1, 10, 10, 10);
        drive_cycle(group, 0, 1'b0);

        // ====================================================
        // exhaustion, then release-first recovery
        // ====================================================
        n = 0;
        do begin
            group[0] = random_req(1'b1);
            group[1] = random_req(1'b1);
            drive_cycle(group, 0, 1'b0);
            #2;
            n++;
        end while (!stall && n < WAIT_LIMIT);
        if (!stall) begin
            timeouts++;
            $display("timeout: free list never ran short");
        end
        // held group, count must not move
        drive_cycle(group, 0, 1'b0);
        n = 0;
        do begin
            drive_cycle(group, 1, 1'b0);
            #2;
            n++;
        end while (stall && n < WAIT_LIMIT);
        if (stall) begin
            timeouts++;
            $display("timeout: stall stayed high while registers were released");
        end

        // recycled regs come out after the older free ones
        repeat (4) drive_cycle('0, 2, 1'b0);
        repeat (6) begin
            group[0] = random_req(1'b1);
            group[1] = random_req(1'b1);
            drive_cycle(group, 0, 1'b0);
        end

        // flush with renames in flight, sources from the committed map
        group[0] = random_req(1'b1);
        group[1] = random_req(1'b0);
        drive_cycle(group, 1, 1'b1);
        group[0] = make_req(1'b0, 0, 3, 4);
        group[1] = make_req(1'b0, 0, 10, 7);
        drive_cycle(group, 0, 1'b0);

        // random traffic
        repeat (300) begin
            group[0] = random_req(1'b0);
            group[1] = random_req(1'b0);
            drive_cycle(group, $unsigned($random(seed)) % 3, $random(seed) % 32 == 0);
        end

        // drain in-flight renames
        n = 0;
        while (inflight_q.size() > 0 && n < WAIT_LIMIT) begin
            drive_cycle('0, 2, 1'b0);
            n++;
        end
        if (inflight_q.size() > 0) begin
            timeouts++;
            $display("timeout: in-flight renames did not drain");
        end
        drive_cycle('0, 0, 1'b0);
        @(posedge clock);
        #1;

        $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/rename_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/arch_map.sv
logic/rename_stage.sv
sim/tb_clock_gen.sv
sim/rename_tb.sv

// ==== Makefile ====
# Verilator build and run for the rename stage testbench

SOURCES := $(shell grep -v '^+' tb.f)

.PHONY: all run clean

all: run

# rebuilt only when the file list or a source changes
obj_dir/Vrename_tb: tb.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module rename_tb -f tb.f

# status follows the verdict line in the output
run: obj_dir/Vrename_tb
	@out="$$(./obj_dir/Vrename_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
